/* testbench/cpu_stimulus.txt */
# Records: P <budget cycles> <halts 0|1>, W <addr> <data>, E <expected out_value>, X ends it
# Addresses, data and expected values are hex; words not listed hold HLT
# 1 load and output
P 30 1
W 0 4F  W 1 50  W 2 00  W F A7
E A7  X
# 2 add with wrap past 255, subtract below 0
P 48 1
W 0 4D  W 1 2E  W 2 50  W 3 3F  W 4 50  W 5 00  W D F0  W E 25  W F 30
E 15  E E5  X
# 3 store to a fresh address, reload and output
P 54 1
W 0 4E  W 1 2F  W 2 6C  W 3 4F  W 4 4C  W 5 50  W 6 00  W E 40  W F 02
E 42  X
# 4 jump over an output
P 48 1
W 0 4E  W 1 73  W 2 50  W 3 2F  W 4 50  W 5 00  W E 11  W F 22
E 33  X
# 5 backward jump loop, never halts
P 80 0
W 0 4E  W 1 50  W 2 2F  W 3 71  W E 05  W F 03
E 05  E 08  E 0B  E 0E  X
# 6 output right after reset
P 24 1
W 0 50  W 1 00
E 00  X
# 7 program 2 with NOP and unused opcodes mixed in
P 72 1
W 0 4D  W 1 10  W 2 2E  W 3 85  W 4 50  W 5 F3  W 6 3F  W 7 A0  W 8 50  W 9 00
W D F0  W E 25  W F 30
E 15  E E5  X

/* files.f */
source/sap_pkg.sv
source/control_sequencer.sv
source/fetch_unit.sv
source/memory_unit.sv
source/arith_unit.sv
source/sap_cpu.sv
testbench/tb_sap_cpu.sv

/* testbench/tb_sap_cpu.sv */
// Testbench for the accumulator CPU, runs every program listed in the stimulus file
// Each program is loaded through the reset-time port, then outputs and halting are checked

`default_nettype none

module tb_sap_cpu
    import sap_pkg::*;
();

    localparam int reset_cycles  = 4;
    localparam int tail_cycles   = 12;  // Two instruction times after the halt
    localparam int margin_cycles = 50;

    logic              clk = 1'b1;  // First edge is a falling one
    logic              rst_n;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    logic [data_w-1:0] prog_data;
    logic [data_w-1:0] out_value;
    logic              out_valid;
    logic              halted;

    // Parsed stimulus, one entry per program in the index queues
    int                budget_q[$];
    logic              halts_q[$];
    int                word_first_q[$];
    int                word_end_q[$];
    int                exp_first_q[$];
    int                exp_end_q[$];
    logic [addr_w-1:0] word_addr_q[$];
    logic [data_w-1:0] word_data_q[$];
    logic [data_w-1:0] exp_q[$];
    logic [data_w-1:0] got_q[$];
    logic              seen_halt;

    int data_errors  = 0;
    int flag_errors  = 0;
    int other_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    sap_cpu DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, the run went past its limit of %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] expected,
                    input string label);
        if (got !== expected) begin
            $display("[ERROR] out_value %s: got 0x%h, expected 0x%h", label, got, expected);
            data_errors++;
        end
    endtask

    task check_flag(input logic got, input logic expected, input string label);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", label, got, expected);
            flag_errors++;
        end
    endtask

    task read_stimulus();
        int                fd;
        int                code;
        int                v1;
        int                v2;
        logic [31:0]       tag;
        logic [8*128-1:0]  rest;
        fd = $fopen("testbench/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/cpu_stimulus.txt");
            other_errors++;
        end else begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);  // Comment to end of line
                    "P": begin
                        code = $fscanf(fd, "%d %d", v1, v2);
                        budget_q.push_back(v1);
                        halts_q.push_back(v2[0]);
                        word_first_q.push_back(word_addr_q.size());
                        exp_first_q.push_back(exp_q.size());
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", v1, v2);
                        word_addr_q.push_back(v1[addr_w-1:0]);
                        word_data_q.push_back(v2[data_w-1:0]);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", v1);
                        exp_q.push_back(v1[data_w-1:0]);
                    end
                    "X": begin
                        word_end_q.push_back(word_addr_q.size());
                        exp_end_q.push_back(exp_q.size());
                    end
                    default: begin
                        $display("unknown record in the stimulus file");
                        other_errors++;
                    end
                endcase
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
        cycle_limit = reset_cycles + margin_cycles;
        foreach (budget_q[i]) begin
            cycle_limit += budget_q[i] + ram_depth + tail_cycles + 8;  // Load and release
        end
    endtask

    task load_program(input int p);
        logic [data_w-1:0] image [ram_depth];
        int                a;
        int                w;
        for (a = 0; a < ram_depth; a++) begin
            image[a] = {{(data_w-addr_w){1'b0}}, a[addr_w-1:0]};  // HLT with its own address
        end
        for (w = word_first_q[p]; w < word_end_q[p]; w++) begin
            image[word_addr_q[w]] = word_data_q[w];
        end
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);  // Core is in reset from here on
        for (a = 0; a < ram_depth; a++) begin
            @(posedge clk);
            check_flag(halted, 1'b0, "halted during reset");
            check_flag(out_valid, 1'b0, "out_valid during reset");
            prog_we   <= 1'b1;
            prog_addr <= a[addr_w-1:0];
            prog_data <= image[a];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // One clock of observation
    task sample_cycle();
        @(posedge clk);
        if (out_valid) begin
            got_q.push_back(out_value);
        end
        seen_halt = seen_halt | halted;
    endtask

    task run_program(input int p);
        int n;
        int count;
        int e;
        got_q.delete();
        seen_halt = 1'b0;
        n = 0;
        count = exp_end_q[p] - exp_first_q[p];
        @(posedge clk);
        rst_n <= 1'b1;
        while (n < budget_q[p] && !(halts_q[p] && seen_halt)) begin
            sample_cycle();
            n++;
        end
        if (seen_halt) begin
            repeat (tail_cycles) sample_cycle();  // Nothing may follow the halt
        end
        if (halts_q[p] && !seen_halt) begin
            $display("program %0d did not halt within %0d cycles", p, budget_q[p]);
            other_errors++;
        end else begin
            check_flag(seen_halt, halts_q[p], $sformatf("halted, program %0d", p));
        end
        if (got_q.size() != count) begin
            $display("program %0d produced %0d outputs, expected %0d", p, got_q.size(), count);
            other_errors++;
        end
        for (e = 0; e < count && e < got_q.size(); e++) begin
            check_data(got_q[e], exp_q[exp_first_q[p] + e],
                       $sformatf("program %0d output %0d", p, e));
        end
    endtask

    initial begin
        int p;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_stimulus();
        repeat (reset_cycles) @(posedge clk);
        if (word_end_q.size() == 0) begin
            $display("no complete program found in the stimulus file");
            other_errors++;
        end
        for (p = 0; p < word_end_q.size(); p++) begin
            load_program(p);
            run_program(p);
        end
        $display("errors: data %0d, flag %0d, other %0d", data_errors, flag_errors, other_errors);
        if (data_errors + flag_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/sap_cpu.sv */
// Top level of the bus-based accumulator CPU
// Muxes the shared bus from the enabled source and ties the four blocks together

`default_nettype none

module sap_cpu
    import sap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                prog_we,
    input  logic [addr_w-1:0]   prog_addr,
    input  logic [data_w-1:0]   prog_data,
    output logic [data_w-1:0]   out_value,
    output logic                out_valid,
    output logic                halted
);

    control_word_t     ctrl;
    opcode_t           opcode;
    logic [data_w-1:0] w_bus;
    logic [addr_w-1:0] pc_value;
    logic [addr_w-1:0] ir_operand;
    logic [data_w-1:0] ram_data;
    logic [data_w-1:0] rega_value;
    logic [data_w-1:0] alu_result;

    // Shared bus, enables are one-hot so the order does not matter
    always_comb begin
        w_bus = '0;
        if (ctrl.pc_en) begin
            w_bus = {{(data_w-addr_w){1'b0}}, pc_value};
        end else if (ctrl.ir_en) begin
            w_bus = {{(data_w-addr_w){1'b0}}, ir_operand};
        end else if (ctrl.ram_en) begin
            w_bus = ram_data;
        end else if (ctrl.rega_en) begin
            w_bus = rega_value;
        end else if (ctrl.regb_en) begin
            w_bus = alu_result;  // Sum or difference
        end
    end

    control_sequencer u_sequencer (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .w_bus      (w_bus),
        .pc_value   (pc_value),
        .ir_operand (ir_operand),
        .opcode     (opcode)
    );

    memory_unit u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .w_bus     (w_bus),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ram_data  (ram_data)
    );

    arith_unit u_arith (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .w_bus      (w_bus),
        .rega_value (rega_value),
        .alu_result (alu_result),
        .out_value  (out_value),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

/* source/arith_unit.sv */
// Accumulator, B register, adder-subtractor and output register of the accumulator CPU
// out_valid pulses for one cycle each time the output register loads

`default_nettype none

module arith_unit
    import sap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  control_word_t       ctrl,
    input  logic [data_w-1:0]   w_bus,
    output logic [data_w-1:0]   rega_value,
    output logic [data_w-1:0]   alu_result,
    output logic [data_w-1:0]   out_value,
    output logic                out_valid
);

    logic [data_w-1:0] rega;
    logic [data_w-1:0] regb;

    // Accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rega <= '0;
        end else if (ctrl.rega_load) begin
            rega <= w_bus;
        end
    end

    // B operand
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regb <= '0;
        end else if (ctrl.regb_load) begin
            regb <= w_bus;
        end
    end

    // Modulo 256 on both paths
    always_comb begin
        if (ctrl.alu_sub) begin
            alu_result = rega - regb;
        end else begin
            alu_result = rega + regb;
        end
    end

    // Output register and its strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_value <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load;  // High for the cycle after the load
            if (ctrl.out_load) begin
                out_value <= w_bus;
            end
        end
    end

    assign rega_value = rega;

endmodule

`default_nettype wire

/* source/memory_unit.sv */
// Address register, data holding register and 16-word RAM of the accumulator CPU
// The program-load port writes the RAM only while the core is held in reset

`default_nettype none

module memory_unit
    import sap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  control_word_t       ctrl,
    input  logic [data_w-1:0]   w_bus,
    input  logic                prog_we,
    input  logic [addr_w-1:0]   prog_addr,
    input  logic [data_w-1:0]   prog_data,
    output logic [data_w-1:0]   ram_data
);

    logic [addr_w-1:0] mar;
    logic [data_w-1:0] mdr;
    logic [data_w-1:0] ram [ram_depth];

    // Memory address register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.mar_addr_load) begin
            mar <= w_bus[addr_w-1:0];
        end
    end

    // Data holding register for STA
    always_ff @(posedge clk) begin
        if (ctrl.mar_mem_load) begin
            mdr <= w_bus;
        end
    end

    // Loader port in reset, store path afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if (prog_we) begin
                ram[prog_addr] <= prog_data;
            end
        end else if (ctrl.ram_load) begin
            ram[mar] <= mdr;
        end
    end

    assign ram_data = ram[mar];  // Asynchronous read

    // Loader writes after release would race the running program
    a_prog_in_reset: assert property (@(posedge clk) rst_n |-> !prog_we)
        else $error("prog_we asserted outside reset");

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
// Program counter and instruction register of the accumulator CPU
// Both load from the shared bus on the rising edge under the control word

`default_nettype none

module fetch_unit
    import sap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  control_word_t       ctrl,
    input  logic [data_w-1:0]   w_bus,
    output logic [addr_w-1:0]   pc_value,
    output logic [addr_w-1:0]   ir_operand,
    output opcode_t             opcode
);

    logic [addr_w-1:0] pc;
    logic [data_w-1:0] ir_word;

    // Program counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= w_bus[addr_w-1:0];  // Jump target from operand
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;  // Wraps at 16
        end
    end

    // Instruction register, holds NOP after reset so t1 still increments
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_word <= {op_nop, {addr_w{1'b0}}};
        end else if (ctrl.ir_load) begin
            ir_word <= w_bus;
        end
    end

    assign pc_value   = pc;
    assign ir_operand = ir_word[addr_w-1:0];
    assign opcode     = opcode_t'(ir_word[data_w-1:addr_w]);  // Codes 8 to 15 kept as is

endmodule

`default_nettype wire

/* source/control_sequencer.sv */
// Step counter and microcode decode for the accumulator CPU
// Steps advance on the falling edge so the control word is settled before each rising edge

`default_nettype none

module control_sequencer
    import sap_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  opcode_t       opcode,
    output control_word_t ctrl,
    output logic          halted
);

    step_t step;

    // Step register, parked in t_hold through reset
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            step   <= t_hold;
            halted <= 1'b0;
        end else begin
            case (step)
                t_hold:  step <= t0;
                t5:      step <= t0;  // Six steps per instruction
                default: step <= step_t'(step + 3'd1);
            endcase
            if (step == t3 && opcode == op_hlt) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    // Microcode decode
    always_comb begin
        ctrl = ctrl_idle;
        case (step)
            t0: begin
                ctrl.pc_en         = 1'b1;
                ctrl.mar_addr_load = 1'b1;
            end
            t1: begin
                if (opcode != op_hlt) begin
                    ctrl.pc_inc = 1'b1;
                end
            end
            t2: begin
                ctrl.ram_en  = 1'b1;
                ctrl.ir_load = !halted;  // Keep HLT in the IR once halted
            end
            t3: begin
                case (opcode)
                    op_add, op_sub, op_lda, op_sta: begin
                        ctrl.ir_en         = 1'b1;
                        ctrl.mar_addr_load = 1'b1;
                    end
                    op_out: begin
                        ctrl.rega_en  = 1'b1;
                        ctrl.out_load = 1'b1;
                    end
                    op_jmp: begin
                        ctrl.ir_en   = 1'b1;
                        ctrl.pc_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            t4: begin
                case (opcode)
                    op_add, op_sub: begin
                        ctrl.ram_en    = 1'b1;
                        ctrl.regb_load = 1'b1;
                    end
                    op_lda: begin
                        ctrl.ram_en    = 1'b1;
                        ctrl.rega_load = 1'b1;
                    end
                    op_sta: begin
                        ctrl.rega_en      = 1'b1;
                        ctrl.mar_mem_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            t5: begin
                case (opcode)
                    op_add, op_sub: begin
                        ctrl.alu_sub   = (opcode == op_sub);
                        ctrl.regb_en   = 1'b1;
                        ctrl.rega_load = 1'b1;
                    end
                    op_sta: ctrl.ram_load = 1'b1;
                    default: ;
                endcase
            end
            default: ;  // t_hold stays idle
        endcase
    end

    // Bus contention would corrupt every block loading in that step
    a_bus_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.pc_en, ctrl.ir_en, ctrl.ram_en, ctrl.rega_en, ctrl.regb_en}))
        else $error("multiple bus drivers");

    a_step_legal: assert property (@(posedge clk)
        step inside {t0, t1, t2, t3, t4, t5, t_hold})
        else $error("illegal step %0d", step);

    a_pc_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.pc_inc && ctrl.pc_load))
        else $error("pc_inc with pc_load");

endmodule

`default_nettype wire

/* source/sap_pkg.sv */
// Shared widths, opcodes, step encoding and control word for the accumulator CPU
// Imported by every RTL block of the core

`default_nettype none

package sap_pkg;

    localparam int data_w    = 8;   // Bus and register width
    localparam int addr_w    = 4;   // Memory address width
    localparam int ram_depth = 16;  // Words of program and data memory

    // Upper nibble of an instruction word, codes 8 to 15 behave as NOP
    typedef enum logic [3:0] {
        op_hlt = 4'h0,
        op_nop = 4'h1,
        op_add = 4'h2,
        op_sub = 4'h3,
        op_lda = 4'h4,
        op_out = 4'h5,
        op_sta = 4'h6,
        op_jmp = 4'h7
    } opcode_t;

    // Micro-operation steps, t_hold only while in reset
    typedef enum logic [2:0] {
        t0     = 3'd0,
        t1     = 3'd1,
        t2     = 3'd2,
        t3     = 3'd3,
        t4     = 3'd4,
        t5     = 3'd5,
        t_hold = 3'd6
    } step_t;

    // One bit per datapath strobe, all active high
    typedef struct packed {
        logic pc_inc;         // Program counter increment
        logic pc_en;          // PC onto bus
        logic pc_load;        // PC from bus
        logic mar_addr_load;  // Address register from bus
        logic mar_mem_load;   // Data holding register from bus
        logic ram_en;         // RAM read data onto bus
        logic ram_load;       // RAM write
        logic ir_load;        // Instruction register from bus
        logic ir_en;          // Operand onto bus
        logic rega_load;      // Accumulator from bus
        logic rega_en;        // Accumulator onto bus
        logic alu_sub;        // Subtract instead of add
        logic regb_en;        // ALU result onto bus
        logic regb_load;      // B register from bus
        logic out_load;       // Output register from bus
    } control_word_t;

    // Nothing driven, nothing loaded
    localparam control_word_t ctrl_idle = '0;

endpackage

`default_nettype wire
